// File: common/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// one fixed memory geometry, 4 KiB of 32-bit words
`define MEM_DEPTH_WORDS 1024
`define MEM_INDEX_BITS 10 // log2 of depth

// cycles from the accepting edge to the valid cycle
`define MEM_READ_LATENCY 3
`define MEM_LAT_CNT_BITS 2 // wide enough to hold the latency

`endif

// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

`include "mem_defines.svh"

    typedef logic [31:0] word_t; // data word
    typedef logic [31:0] addr_t; // byte address, bits 11:2 pick the word
    typedef logic [31:0] mask_t; // bit write mask, 1 = write

    typedef logic [`MEM_INDEX_BITS-1:0] index_t;
    typedef logic [`MEM_LAT_CNT_BITS-1:0] lat_cnt_t;

    typedef enum logic [1:0] {
        wait_cmd,       // idle, ready for new requests
        wait_mem_ready, // command held until memory is ready
        wait_mem_read   // read in flight
    } arb_state_e;

endpackage

`default_nettype wire

// File: common/mem_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_cmd_if
    import mem_pkg::*;
();

    logic  cmd_start;
    logic  cmd_write;
    logic  cmd_ready;
    addr_t addr;
    word_t wdata;
    mask_t wmask;
    word_t rdata;
    logic  rdata_valid;

    // arbiter side issues commands
    modport arbiter (
        output cmd_start, cmd_write, addr, wdata, wmask,
        input  cmd_ready, rdata, rdata_valid
    );

    // memory side answers them
    modport memory (
        input  cmd_start, cmd_write, addr, wdata, wmask,
        output cmd_ready, rdata, rdata_valid
    );

endinterface

`default_nettype wire

// File: hw/memory/mem_latency_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module mem_latency_timer
    import mem_pkg::*;
(
    input  wire  clk,
    input  wire  rst_n,
    input  wire  read_accept,
    output logic cmd_ready,
    output logic rdata_valid
);

    lat_cnt_t count_q; // cycles left until the read word is valid

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (read_accept) begin
            count_q <= lat_cnt_t'(`MEM_READ_LATENCY);
        end else if (count_q != '0) begin
            count_q <= count_q - lat_cnt_t'(1);
        end
    end

    // last count: word valid and memory free again
    assign rdata_valid = (count_q == lat_cnt_t'(1));
    assign cmd_ready   = (count_q <= lat_cnt_t'(1));

endmodule

`default_nettype wire

// File: hw/memory/mem_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module mem_array
    import mem_pkg::*;
(
    input  wire  clk,
    mem_cmd_if.memory mem,
    output logic read_accept
);

    word_t  mem_q [`MEM_DEPTH_WORDS];
    word_t  rdata_q; // held until the timer flags it valid
    index_t idx;
    logic   accept;

    // array comes up cleared
    initial begin
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    assign idx         = mem.addr[`MEM_INDEX_BITS+1:2]; // word select
    assign accept      = mem.cmd_start && mem.cmd_ready;
    assign read_accept = accept && !mem.cmd_write;

    always_ff @(posedge clk) begin
        if (accept && mem.cmd_write) begin
            // keep old bits where the mask is zero
            mem_q[idx] <= (mem_q[idx] & ~mem.wmask) | (mem.wdata & mem.wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (read_accept) begin
            rdata_q <= mem_q[idx];
        end
    end

    assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/arbiter/req_capture.sv
`timescale 1ns/10ps
`default_nettype none

module req_capture
    import mem_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   capture_en,
    input  wire   d_cmd_start,
    input  wire   d_cmd_write,
    input  addr_t d_addr,
    input  word_t wdata,
    input  mask_t wmask,
    input  wire   fetch_done,
    input  wire   load_done,
    input  word_t mem_rdata,
    input  wire   issue_saved,

    output logic  saved_pending,
    output logic  saved_write,
    output addr_t saved_addr,
    output word_t saved_wdata,
    output mask_t saved_wmask,
    output word_t inst,
    output word_t rdata
);

    word_t inst_q;
    word_t rdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saved_pending <= 1'b0;
            saved_write   <= 1'b0;
            inst_q        <= '0;
            rdata_q       <= '0;
        end else begin
            if (capture_en) begin
                saved_pending <= d_cmd_start;
                saved_write   <= d_cmd_write;
            end else if (issue_saved) begin
                saved_pending <= 1'b0;
            end
            if (fetch_done) begin
                inst_q <= mem_rdata;
            end
            if (load_done) begin
                rdata_q <= mem_rdata;
            end
        end
    end

    // payload of the saved data command
    always_ff @(posedge clk) begin
        if (capture_en) begin
            saved_addr  <= d_addr;
            saved_wdata <= wdata;
            saved_wmask <= wmask;
        end
    end

    // memory word passes straight through in the valid cycle
    assign inst  = fetch_done ? mem_rdata : inst_q;
    assign rdata = load_done ? mem_rdata : rdata_q;

endmodule

`default_nettype wire

// File: hw/arbiter/arb_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module arb_fsm
    import mem_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   halt,
    input  wire   inst_start,
    input  wire   d_cmd_start,
    input  addr_t i_addr,

    input  wire   saved_pending,
    input  wire   saved_write,
    input  addr_t saved_addr,
    input  word_t saved_wdata,
    input  mask_t saved_wmask,

    input  wire   d_cmd_write,
    input  addr_t d_addr,
    input  word_t wdata,
    input  mask_t wmask,

    output logic  inst_ready,
    output logic  d_cmd_ready,
    output logic  inst_valid,
    output logic  rdata_valid,
    output logic  capture_en,
    output logic  fetch_done,
    output logic  load_done,

    mem_cmd_if.arbiter mem
);

    arb_state_e state_q;
    arb_state_e state_d;
    logic       cur_fetch_q; // read in flight belongs to the fetch port
    logic       cur_fetch_d;
    addr_t      fetch_addr_q; // fetch address kept for a late issue
    logic       accept;
    logic       fetch_ret;
    logic       load_ret;

    assign accept = (state_q == wait_cmd) && !halt && (inst_start || d_cmd_start);

    // which requester the returning read belongs to
    assign fetch_ret = (state_q == wait_mem_read) && mem.rdata_valid && cur_fetch_q;
    assign load_ret  = (state_q == wait_mem_read) && mem.rdata_valid && !cur_fetch_q;

    assign inst_ready  = (state_q == wait_cmd) && !halt;
    assign d_cmd_ready = (state_q == wait_cmd) && !halt;
    assign inst_valid  = fetch_ret;
    assign fetch_done  = fetch_ret;
    assign rdata_valid = load_ret;
    assign load_done   = load_ret;
    assign capture_en  = accept;

    always_comb begin
        state_d       = state_q;
        cur_fetch_d   = cur_fetch_q;
        mem.cmd_start = 1'b0;
        mem.cmd_write = 1'b0;
        mem.addr      = saved_addr; // saved command unless the live one goes out
        mem.wdata     = saved_wdata;
        mem.wmask     = saved_wmask;
        case (state_q)
            wait_cmd: begin
                if (accept) begin
                    cur_fetch_d = inst_start; // fetch wins a tie
                    if (!mem.cmd_ready) begin
                        state_d = wait_mem_ready;
                    end else if (inst_start) begin
                        mem.cmd_start = 1'b1;
                        mem.addr      = i_addr;
                        state_d       = wait_mem_read;
                    end else begin
                        mem.cmd_start = 1'b1;
                        mem.cmd_write = d_cmd_write;
                        mem.addr      = d_addr;
                        mem.wdata     = wdata;
                        mem.wmask     = wmask;
                        state_d       = d_cmd_write ? wait_cmd : wait_mem_read;
                    end
                end
            end
            wait_mem_ready: begin
                if (mem.cmd_ready) begin
                    mem.cmd_start = 1'b1;
                    if (cur_fetch_q) begin
                        mem.addr = fetch_addr_q;
                        state_d  = wait_mem_read;
                    end else begin
                        mem.cmd_write = saved_write;
                        state_d       = saved_write ? wait_cmd : wait_mem_read;
                    end
                end
            end
            wait_mem_read: begin
                if (fetch_ret && saved_pending) begin
                    cur_fetch_d = 1'b0; // data command follows the fetch
                    if (mem.cmd_ready) begin
                        mem.cmd_start = 1'b1;
                        mem.cmd_write = saved_write;
                        state_d       = saved_write ? wait_cmd : wait_mem_read;
                    end else begin
                        state_d = wait_mem_ready;
                    end
                end else if (mem.rdata_valid) begin
                    state_d = wait_cmd;
                end
            end
            default: state_d = wait_cmd;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= wait_cmd;
            cur_fetch_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cur_fetch_q <= cur_fetch_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_addr_q <= i_addr;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_interface_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_interface_top
    import mem_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,

    input  wire   inst_start,
    output logic  inst_ready,
    input  addr_t i_addr,
    output word_t inst,
    output logic  inst_valid,

    input  wire   d_cmd_start,
    input  wire   d_cmd_write,
    output logic  d_cmd_ready,
    input  addr_t d_addr,
    input  word_t wdata,
    input  mask_t wmask,
    output word_t rdata,
    output logic  rdata_valid,

    input  wire   halt
);

    logic  saved_pending;
    logic  saved_write;
    addr_t saved_addr;
    word_t saved_wdata;
    mask_t saved_wmask;
    logic  capture_en;
    logic  fetch_done;
    logic  load_done;
    logic  read_accept;

    mem_cmd_if mem_if ();

    arb_fsm arb_fsm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .halt          (halt),
        .inst_start    (inst_start),
        .d_cmd_start   (d_cmd_start),
        .i_addr        (i_addr),
        .saved_pending (saved_pending),
        .saved_write   (saved_write),
        .saved_addr    (saved_addr),
        .saved_wdata   (saved_wdata),
        .saved_wmask   (saved_wmask),
        .d_cmd_write   (d_cmd_write),
        .d_addr        (d_addr),
        .wdata         (wdata),
        .wmask         (wmask),
        .inst_ready    (inst_ready),
        .d_cmd_ready   (d_cmd_ready),
        .inst_valid    (inst_valid),
        .rdata_valid   (rdata_valid),
        .capture_en    (capture_en),
        .fetch_done    (fetch_done),
        .load_done     (load_done),
        .mem           (mem_if.arbiter)
    );

    req_capture req_capture_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_en    (capture_en),
        .d_cmd_start   (d_cmd_start),
        .d_cmd_write   (d_cmd_write),
        .d_addr        (d_addr),
        .wdata         (wdata),
        .wmask         (wmask),
        .fetch_done    (fetch_done),
        .load_done     (load_done),
        .mem_rdata     (mem_if.rdata),
        .issue_saved   (fetch_done), // saved command goes out when the fetch returns
        .saved_pending (saved_pending),
        .saved_write   (saved_write),
        .saved_addr    (saved_addr),
        .saved_wdata   (saved_wdata),
        .saved_wmask   (saved_wmask),
        .inst          (inst),
        .rdata         (rdata)
    );

    mem_latency_timer mem_latency_timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_accept (read_accept),
        .cmd_ready   (mem_if.cmd_ready),
        .rdata_valid (mem_if.rdata_valid)
    );

    mem_array mem_array_i (
        .clk         (clk),
        .mem         (mem_if.memory),
        .read_accept (read_accept)
    );

endmodule

`default_nettype wire

// File: dv/mem_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mem_checker
    import mem_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   inst_valid,
    input  word_t inst,
    input  wire   rdata_valid,
    input  word_t rdata
);

    string name_q = "idle";
    logic  want_inst_q = 1'b0; // a fetch response is due
    logic  want_rdata_q = 1'b0; // a load response is due
    word_t exp_inst_q = '0;
    word_t exp_rdata_q = '0;
    int    error_count = 0;

    task automatic set_expect(input string name, input logic want_inst, input logic want_rdata,
                              input word_t exp_inst, input word_t exp_rdata);
        name_q       <= name;
        want_inst_q  <= want_inst;
        want_rdata_q <= want_rdata;
        exp_inst_q   <= exp_inst;
        exp_rdata_q  <= exp_rdata;
    endtask

    function automatic void compare(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("error: %s expected %08h actual %08h", what, expected, actual);
        end
    endfunction

    // outputs are settled half a cycle after the rising edge
    always @(negedge clk) begin
        if (rst_n && inst_valid) begin
            if (!want_inst_q) begin
                error_count++;
                $display("%s: inst_valid pulsed while no fetch was outstanding", name_q);
            end else begin
                compare({name_q, " inst"}, exp_inst_q, inst);
            end
        end
        if (rst_n && rdata_valid) begin
            if (!want_rdata_q) begin
                error_count++;
                $display("%s: rdata_valid pulsed while no load was outstanding", name_q);
            end else begin
                compare({name_q, " rdata"}, exp_rdata_q, rdata);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/mem_interface_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module mem_interface_properties (
    input  wire clk,
    input  wire rst_n,
    input  wire inst_ready,
    input  wire d_cmd_ready,
    input  wire inst_valid,
    input  wire rdata_valid,
    input  wire cmd_start,
    input  wire cmd_write,
    input  wire cmd_ready,
    input  wire mem_rdata_valid
);

    int fail_count = 0; // failed assertions so far

    // requesters see no ready while a read is in flight
    ready_low_during_read: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_start && !cmd_write && cmd_ready)
            |=> (!inst_ready && !d_cmd_ready) [*`MEM_READ_LATENCY])
    else begin
        fail_count++;
        $error("ready output high while a read was in flight");
    end

    inst_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |=> !inst_valid)
    else begin
        fail_count++;
        $error("inst_valid stayed high for more than one cycle");
    end

    rdata_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |=> !rdata_valid)
    else begin
        fail_count++;
        $error("rdata_valid stayed high for more than one cycle");
    end

    // accepted read keeps the memory busy until its word is valid
    read_busy_until_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_start && !cmd_write && cmd_ready)
            |=> !cmd_ready [*`MEM_READ_LATENCY-1] ##1 (cmd_ready && mem_rdata_valid))
    else begin
        fail_count++;
        $error("memory was ready again before the read word was valid");
    end

endmodule

bind arb_fsm mem_interface_properties props_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .inst_ready      (inst_ready),
    .d_cmd_ready     (d_cmd_ready),
    .inst_valid      (inst_valid),
    .rdata_valid     (rdata_valid),
    .cmd_start       (mem.cmd_start),
    .cmd_write       (mem.cmd_write),
    .cmd_ready       (mem.cmd_ready),
    .mem_rdata_valid (mem.rdata_valid)
);

`default_nettype wire

// File: dv/mem_interface_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_interface_tb
    import mem_pkg::*;
();

    localparam int num_entries    = 10;
    localparam int read_latency   = 3;
    localparam int timeout_cycles = 50;
    localparam int halt_cycles    = 20;

    typedef enum logic [2:0] {
        op_fetch,
        op_load,
        op_store,
        op_fetch_and_load,
        op_fetch_and_store
    } op_e;

    typedef struct packed {
        op_e   op;
        logic  halt_first; // hold halt before the request
        addr_t i_addr;
        addr_t d_addr;
        word_t wdata;
        mask_t wmask;
        word_t exp_inst;
        word_t exp_rdata;
    } entry_t;

    logic   clk;
    logic   rst_n;
    logic   inst_start;
    logic   inst_ready;
    addr_t  i_addr;
    word_t  inst;
    logic   inst_valid;
    logic   d_cmd_start;
    logic   d_cmd_write;
    logic   d_cmd_ready;
    addr_t  d_addr;
    word_t  wdata;
    mask_t  wmask;
    word_t  rdata;
    logic   rdata_valid;
    logic   halt;
    entry_t entries [num_entries];
    string  names [num_entries];
    int     timeouts = 0;
    int     total_errors;

    mem_interface_top dut_i (.*);

    mem_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .rdata_valid (rdata_valid),
        .rdata       (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fill_table();
        // op, halt_first, i_addr, d_addr, wdata, wmask, exp_inst, exp_rdata
        names[0]   = "fetch_unwritten";
        entries[0] = '{op_fetch, 1'b0, 32'h0000_0100, 0, 0, 0, 0, 0};
        names[1]   = "store_full";
        entries[1] = '{op_store, 1'b0, 0, 32'h0000_0040, 32'hdead_beef, 32'hffff_ffff, 0, 0};
        names[2]   = "load_full";
        entries[2] = '{op_load, 1'b0, 0, 32'h0000_0040, 0, 0, 0, 32'hdead_beef};
        names[3]   = "store_partial";
        entries[3] = '{op_store, 1'b0, 0, 32'h0000_0040, 32'h1234_5678, 32'h0000_ff0f, 0, 0};
        names[4]   = "load_partial"; // old bits kept where the mask is zero
        entries[4] = '{op_load, 1'b0, 0, 32'h0000_0040, 0, 0, 0, 32'hdead_56e8};
        names[5]   = "store_code";
        entries[5] = '{op_store, 1'b0, 0, 32'h0000_0080, 32'h00a0_0093, 32'hffff_ffff, 0, 0};
        names[6]   = "fetch_and_load";
        entries[6] = '{op_fetch_and_load, 1'b0, 32'h0000_0080, 32'h0000_0040, 0, 0,
                       32'h00a0_0093, 32'hdead_56e8};
        names[7]   = "fetch_and_store";
        entries[7] = '{op_fetch_and_store, 1'b0, 32'h0000_0080, 32'h0000_00c0, 32'hcafe_f00d,
                       32'hffff_ffff, 32'h00a0_0093, 0};
        names[8]   = "load_after_pair";
        entries[8] = '{op_load, 1'b0, 0, 32'h0000_00c0, 0, 0, 0, 32'hcafe_f00d};
        names[9]   = "fetch_after_halt";
        entries[9] = '{op_fetch, 1'b1, 32'h0000_0080, 0, 0, 0, 32'h00a0_0093, 0};
    endtask

    function automatic logic probe(input int which);
        case (which)
            0:       probe = inst_ready && d_cmd_ready;
            1:       probe = inst_valid;
            default: probe = rdata_valid;
        endcase
    endfunction

    // cycles counts falling edges passed before the signal showed up
    task automatic wait_signal(input int which, input string what, output int cycles);
        cycles = 0;
        while (!probe(which) && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!probe(which)) begin
            timeouts++;
            $display("timeout: %s did not arrive within %0d cycles", what, timeout_cycles);
        end
    endtask

    task automatic hold_halt(input string name);
        halt = 1'b1;
        repeat (halt_cycles) begin
            @(negedge clk);
            chk_i.compare({name, " ready during halt"}, 32'd0, {30'd0, inst_ready, d_cmd_ready});
        end
        halt = 1'b0;
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        string  name;
        logic   has_fetch;
        logic   has_load;
        int     cycles;
        e         = entries[idx];
        name      = names[idx];
        has_fetch = e.op inside {op_fetch, op_fetch_and_load, op_fetch_and_store};
        has_load  = e.op inside {op_load, op_fetch_and_load};
        if (e.halt_first) begin
            hold_halt(name);
        end
        chk_i.set_expect(name, has_fetch, has_load, e.exp_inst, e.exp_rdata);
        wait_signal(0, {name, " ready"}, cycles);
        inst_start  = has_fetch;
        d_cmd_start = (e.op != op_fetch);
        d_cmd_write = e.op inside {op_store, op_fetch_and_store};
        i_addr      = e.i_addr;
        d_addr      = e.d_addr;
        wdata       = e.wdata;
        wmask       = e.wmask;
        @(negedge clk); // accepted at the rising edge just passed
        inst_start  = 1'b0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        if (e.op == op_store) begin
            chk_i.compare({name, " d_cmd_ready"}, 32'd1, 32'(d_cmd_ready));
        end
        if (has_fetch) begin
            wait_signal(1, {name, " inst_valid"}, cycles);
            chk_i.compare({name, " fetch latency"}, read_latency, cycles + 1);
        end else if (has_load) begin
            wait_signal(2, {name, " rdata_valid"}, cycles);
            chk_i.compare({name, " load latency"}, read_latency, cycles + 1);
        end
        // saved load goes out in the inst_valid cycle
        if (e.op == op_fetch_and_load) begin
            wait_signal(2, {name, " rdata_valid"}, cycles);
            chk_i.compare({name, " saved load latency"}, read_latency, cycles);
            chk_i.compare({name, " inst held"}, e.exp_inst, inst);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        inst_start  = 1'b0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        halt        = 1'b0;
        i_addr      = '0;
        d_addr      = '0;
        wdata       = '0;
        wmask       = '0;
        fill_table();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_entries; i++) begin
            run_entry(i);
        end
        repeat (5) @(negedge clk);
        total_errors = chk_i.error_count + timeouts + dut_i.arb_fsm_i.props_i.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 chk_i.error_count, timeouts, dut_i.arb_fsm_i.props_i.fail_count);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/mem_pkg.sv
common/mem_cmd_if.sv
hw/memory/mem_latency_timer.sv
hw/memory/mem_array.sv
hw/arbiter/req_capture.sv
hw/arbiter/arb_fsm.sv
hw/mem_interface_top.sv
dv/mem_checker.sv
dv/mem_interface_properties.sv
dv/mem_interface_tb.sv
